// File: design/bus_pkg.sv
/*
 * Bus widths shared by the slave port and the register bus
 */
`default_nettype none

package bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W = DATA_W / 8;

  // Returned for reads outside any peripheral window
  localparam logic [DATA_W-1:0] UNMAPPED_RDATA = 32'hBADCAB1E;

  // Merge write data into a register under byte enables
  function automatic logic [DATA_W-1:0] apply_be(input logic [DATA_W-1:0] old_v,
                                                 input logic [DATA_W-1:0] new_v,
                                                 input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] res;
    res = old_v;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: design/ao_map_pkg.sv
/*
 * Address map of the always-on region: windows and register offsets
 */
`default_nettype none

package ao_map_pkg;

  localparam int unsigned NUM_PERIPH = 3;

  // 4 KiB per peripheral, index in address bits 13:12
  localparam int unsigned WINDOW_LSB = 12;
  localparam int unsigned WINDOW_BITS = 2;
  localparam int unsigned OFFSET_W = WINDOW_LSB;

  localparam logic [WINDOW_BITS-1:0] SOC_CTRL_IDX = 2'd0;
  localparam logic [WINDOW_BITS-1:0] TIMER_IDX = 2'd1;
  localparam logic [WINDOW_BITS-1:0] POWER_IDX = 2'd2;

  // SoC control
  localparam logic [OFFSET_W-1:0] SOC_CTRL_EXIT_VALID = 12'h000;
  localparam logic [OFFSET_W-1:0] SOC_CTRL_EXIT_VALUE = 12'h004;
  localparam logic [OFFSET_W-1:0] SOC_CTRL_BOOT = 12'h008;

  // Machine timer
  localparam logic [OFFSET_W-1:0] TIMER_MTIME = 12'h000;
  localparam logic [OFFSET_W-1:0] TIMER_CMP = 12'h004;
  localparam logic [OFFSET_W-1:0] TIMER_CTRL = 12'h008;

  // Power manager
  localparam logic [OFFSET_W-1:0] POWER_GATE_EN = 12'h000;
  localparam logic [OFFSET_W-1:0] POWER_WAKE_EN = 12'h004;
  localparam logic [OFFSET_W-1:0] POWER_STATUS = 12'h008;

endpackage

`default_nettype wire

// File: design/obi_to_reg.sv
/*
 * OBI-style slave to register bus bridge, one transaction outstanding
 */
`timescale 1ns/1ps
`default_nettype none

module obi_to_reg (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_i,
  input  logic [bus_pkg::ADDR_W-1:0]  addr_i,
  input  logic                        we_i,
  input  logic [bus_pkg::BE_W-1:0]    be_i,
  input  logic [bus_pkg::DATA_W-1:0]  wdata_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]  rdata_o,
  output logic                        reg_valid_o,
  output logic [bus_pkg::ADDR_W-1:0]  reg_addr_o,
  output logic                        reg_write_o,
  output logic [bus_pkg::BE_W-1:0]    reg_be_o,
  output logic [bus_pkg::DATA_W-1:0]  reg_wdata_o,
  input  logic [bus_pkg::DATA_W-1:0]  reg_rdata_i
);

  typedef enum logic {IDLE, ACCESS} state_e;

  state_e state_q;

  // No grant while the previous response is on the bus
  assign gnt_o = req_i && (state_q == IDLE);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else if (state_q == ACCESS) begin
      state_q <= IDLE;
    end else if (gnt_o) begin
      state_q <= ACCESS;
    end
  end

  // Granted request held for the access cycle
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      reg_addr_o  <= addr_i;
      reg_write_o <= we_i;
      reg_be_o    <= be_i;
      reg_wdata_o <= wdata_i;
    end
  end

  assign reg_valid_o = (state_q == ACCESS);
  assign rvalid_o    = (state_q == ACCESS);
  // Peripheral answers in the access cycle, writes answer zero
  assign rdata_o     = reg_write_o ? '0 : reg_rdata_i;

endmodule

`default_nettype wire

// File: design/reg_decode_demux.sv
/*
 * Register bus window decoder, steers valid out and read data back
 */
`timescale 1ns/1ps
`default_nettype none

module reg_decode_demux (
  input  logic                        reg_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  reg_addr_i,
  output logic [bus_pkg::DATA_W-1:0]  reg_rdata_o,
  output logic                        soc_valid_o,
  output logic                        timer_valid_o,
  output logic                        power_valid_o,
  input  logic [bus_pkg::DATA_W-1:0]  soc_rdata_i,
  input  logic [bus_pkg::DATA_W-1:0]  timer_rdata_i,
  input  logic [bus_pkg::DATA_W-1:0]  power_rdata_i
);

  logic [ao_map_pkg::WINDOW_BITS-1:0] idx;
  logic                               mapped;

  assign idx    = reg_addr_i[ao_map_pkg::WINDOW_LSB +: ao_map_pkg::WINDOW_BITS];
  assign mapped = (idx < ao_map_pkg::NUM_PERIPH);

  // Unmapped windows get no valid, so writes there vanish
  assign soc_valid_o   = reg_valid_i && mapped && (idx == ao_map_pkg::SOC_CTRL_IDX);
  assign timer_valid_o = reg_valid_i && mapped && (idx == ao_map_pkg::TIMER_IDX);
  assign power_valid_o = reg_valid_i && mapped && (idx == ao_map_pkg::POWER_IDX);

  always_comb begin
    reg_rdata_o = bus_pkg::UNMAPPED_RDATA;
    if (mapped) begin
      case (idx)
        ao_map_pkg::SOC_CTRL_IDX: reg_rdata_o = soc_rdata_i;
        ao_map_pkg::TIMER_IDX:    reg_rdata_o = timer_rdata_i;
        ao_map_pkg::POWER_IDX:    reg_rdata_o = power_rdata_i;
        default:                  reg_rdata_o = bus_pkg::UNMAPPED_RDATA;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/soc_ctrl.sv
/*
 * SoC control registers: program exit code and boot strap status
 */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  addr_i,
  input  logic                        write_i,
  input  logic [bus_pkg::BE_W-1:0]    be_i,
  input  logic [bus_pkg::DATA_W-1:0]  wdata_i,
  output logic [bus_pkg::DATA_W-1:0]  rdata_o,
  input  logic                        boot_select_i,
  input  logic                        execute_from_flash_i,
  output logic                        exit_valid_o,
  output logic [bus_pkg::DATA_W-1:0]  exit_value_o
);

  logic [ao_map_pkg::OFFSET_W-1:0] offset;
  logic                            wr;
  logic [1:0]                      boot_q;

  assign offset = addr_i[ao_map_pkg::OFFSET_W-1:0];
  assign wr     = valid_i && write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      boot_q       <= '0;
    end else begin
      boot_q <= {execute_from_flash_i, boot_select_i};
      if (wr && offset == ao_map_pkg::SOC_CTRL_EXIT_VALID && be_i[0]) begin
        exit_valid_o <= wdata_i[0];
      end
      if (wr && offset == ao_map_pkg::SOC_CTRL_EXIT_VALUE) begin
        exit_value_o <= bus_pkg::apply_be(exit_value_o, wdata_i, be_i);
      end
    end
  end

  always_comb begin
    case (offset)
      ao_map_pkg::SOC_CTRL_EXIT_VALID: rdata_o = {31'b0, exit_valid_o};
      ao_map_pkg::SOC_CTRL_EXIT_VALUE: rdata_o = exit_value_o;
      ao_map_pkg::SOC_CTRL_BOOT:       rdata_o = {30'b0, boot_q};
      default:                         rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/ao_timer.sv
/*
 * Machine timer with 32-bit mtime, compare register and enable,
 * raising a registered interrupt when mtime reaches cmp
 */
`timescale 1ns/1ps
`default_nettype none

module ao_timer (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  addr_i,
  input  logic                        write_i,
  input  logic [bus_pkg::BE_W-1:0]    be_i,
  input  logic [bus_pkg::DATA_W-1:0]  wdata_i,
  output logic [bus_pkg::DATA_W-1:0]  rdata_o,
  output logic                        timer_irq_o
);

  logic [ao_map_pkg::OFFSET_W-1:0] offset;
  logic                            wr;
  logic [bus_pkg::DATA_W-1:0]      mtime_q;
  logic [bus_pkg::DATA_W-1:0]      cmp_q;
  logic                            en_q;

  assign offset = addr_i[ao_map_pkg::OFFSET_W-1:0];
  assign wr     = valid_i && write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q     <= '0;
      cmp_q       <= '1;
      en_q        <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      // A bus write to mtime wins over the increment
      if (wr && offset == ao_map_pkg::TIMER_MTIME) begin
        mtime_q <= bus_pkg::apply_be(mtime_q, wdata_i, be_i);
      end else if (en_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && offset == ao_map_pkg::TIMER_CMP) begin
        cmp_q <= bus_pkg::apply_be(cmp_q, wdata_i, be_i);
      end
      if (wr && offset == ao_map_pkg::TIMER_CTRL && be_i[0]) begin
        en_q <= wdata_i[0];
      end
      // Drops again once a larger cmp is written
      timer_irq_o <= en_q && (mtime_q >= cmp_q);
    end
  end

  always_comb begin
    case (offset)
      ao_map_pkg::TIMER_MTIME: rdata_o = mtime_q;
      ao_map_pkg::TIMER_CMP:   rdata_o = cmp_q;
      ao_map_pkg::TIMER_CTRL:  rdata_o = {31'b0, en_q};
      default:                 rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/power_manager.sv
/*
 * CPU power manager: reset then gate on sleep, ungate then
 * release reset after RESET_DELAY cycles on timer wake-up
 */
`timescale 1ns/1ps
`default_nettype none

module power_manager #(
  parameter int unsigned RESET_DELAY = 4
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  addr_i,
  input  logic                        write_i,
  input  logic [bus_pkg::BE_W-1:0]    be_i,
  input  logic [bus_pkg::DATA_W-1:0]  wdata_i,
  output logic [bus_pkg::DATA_W-1:0]  rdata_o,
  input  logic                        core_sleep_i,
  input  logic                        timer_irq_i,
  output logic                        powergate_switch_o,
  output logic                        cpu_subsystem_rst_no
);

  localparam int unsigned CNT_W = (RESET_DELAY > 1) ? $clog2(RESET_DELAY) : 1;

  typedef enum logic [1:0] {
    ST_ON        = 2'd0,
    ST_RESETTING = 2'd1,
    ST_OFF       = 2'd2,
    ST_WAKING    = 2'd3
  } state_e;

  state_e                          state_q;
  logic [CNT_W-1:0]                cnt_q;
  logic                            gate_en_q;
  logic                            wake_en_q;
  logic [ao_map_pkg::OFFSET_W-1:0] offset;
  logic                            wr;

  assign offset = addr_i[ao_map_pkg::OFFSET_W-1:0];
  assign wr     = valid_i && write_i && be_i[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_ON;
      cnt_q     <= '0;
      gate_en_q <= 1'b0;
      wake_en_q <= 1'b0;
    end else begin
      if (wr && offset == ao_map_pkg::POWER_GATE_EN) gate_en_q <= wdata_i[0];
      if (wr && offset == ao_map_pkg::POWER_WAKE_EN) wake_en_q <= wdata_i[0];
      cnt_q <= '0;
      case (state_q)
        ST_ON:        if (core_sleep_i && gate_en_q) state_q <= ST_RESETTING;
        ST_RESETTING: state_q <= ST_OFF;
        ST_OFF:       if (timer_irq_i && wake_en_q) state_q <= ST_WAKING;
        ST_WAKING: begin
          // Power is back, hold reset for RESET_DELAY cycles
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(RESET_DELAY - 1)) state_q <= ST_ON;
        end
        default:      state_q <= ST_ON;
      endcase
    end
  end

  assign powergate_switch_o   = (state_q == ST_OFF);
  assign cpu_subsystem_rst_no = (state_q == ST_ON);

  always_comb begin
    case (offset)
      ao_map_pkg::POWER_GATE_EN: rdata_o = {31'b0, gate_en_q};
      ao_map_pkg::POWER_WAKE_EN: rdata_o = {31'b0, wake_en_q};
      ao_map_pkg::POWER_STATUS:  rdata_o = {30'b0, state_q};
      default:                   rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem: slave bridge, window decoder,
 * SoC control, machine timer and CPU power manager
 */
`timescale 1ns/1ps
`default_nettype none

module ao_peripheral_subsystem #(
  parameter int unsigned RESET_DELAY = 4
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_i,
  input  logic [bus_pkg::ADDR_W-1:0]  addr_i,
  input  logic                        we_i,
  input  logic [bus_pkg::BE_W-1:0]    be_i,
  input  logic [bus_pkg::DATA_W-1:0]  wdata_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]  rdata_o,
  input  logic                        boot_select_i,
  input  logic                        execute_from_flash_i,
  output logic                        exit_valid_o,
  output logic [bus_pkg::DATA_W-1:0]  exit_value_o,
  input  logic                        core_sleep_i,
  output logic                        timer_irq_o,
  output logic                        powergate_switch_o,
  output logic                        cpu_subsystem_rst_no
);

  logic                       reg_valid;
  logic [bus_pkg::ADDR_W-1:0] reg_addr;
  logic                       reg_write;
  logic [bus_pkg::BE_W-1:0]   reg_be;
  logic [bus_pkg::DATA_W-1:0] reg_wdata;
  logic [bus_pkg::DATA_W-1:0] reg_rdata;
  logic                       soc_valid;
  logic                       timer_valid;
  logic                       power_valid;
  logic [bus_pkg::DATA_W-1:0] soc_rdata;
  logic [bus_pkg::DATA_W-1:0] timer_rdata;
  logic [bus_pkg::DATA_W-1:0] power_rdata;
  logic                       timer_irq;

  obi_to_reg obi_to_reg_i (
    .clk_i, .arst_n_i,
    .req_i, .addr_i, .we_i, .be_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o,
    .reg_valid_o(reg_valid), .reg_addr_o(reg_addr), .reg_write_o(reg_write),
    .reg_be_o(reg_be), .reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata)
  );

  reg_decode_demux reg_decode_demux_i (
    .reg_valid_i(reg_valid), .reg_addr_i(reg_addr), .reg_rdata_o(reg_rdata),
    .soc_valid_o(soc_valid), .timer_valid_o(timer_valid), .power_valid_o(power_valid),
    .soc_rdata_i(soc_rdata), .timer_rdata_i(timer_rdata), .power_rdata_i(power_rdata)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i, .arst_n_i,
    .valid_i(soc_valid), .addr_i(reg_addr), .write_i(reg_write),
    .be_i(reg_be), .wdata_i(reg_wdata), .rdata_o(soc_rdata),
    .boot_select_i, .execute_from_flash_i, .exit_valid_o, .exit_value_o
  );

  ao_timer ao_timer_i (
    .clk_i, .arst_n_i,
    .valid_i(timer_valid), .addr_i(reg_addr), .write_i(reg_write),
    .be_i(reg_be), .wdata_i(reg_wdata), .rdata_o(timer_rdata),
    .timer_irq_o(timer_irq)
  );

  power_manager #(
    .RESET_DELAY(RESET_DELAY)
  ) power_manager_i (
    .clk_i, .arst_n_i,
    .valid_i(power_valid), .addr_i(reg_addr), .write_i(reg_write),
    .be_i(reg_be), .wdata_i(reg_wdata), .rdata_o(power_rdata),
    .core_sleep_i, .timer_irq_i(timer_irq),
    .powergate_switch_o, .cpu_subsystem_rst_no
  );

  assign timer_irq_o = timer_irq;

endmodule

`default_nettype wire

// File: bench/ao_bus_checker.sv
/*
 * Handshake and power sequencing assertions for the subsystem
 */
`timescale 1ns/1ps
`default_nettype none

module ao_bus_checker (
  input logic clk_i,
  input logic arst_n_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic exit_valid_o,
  input logic timer_irq_o,
  input logic powergate_switch_o,
  input logic cpu_subsystem_rst_no
);

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_o |=> rvalid_o) else $error("rvalid_o missing one cycle after grant");

  rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o |-> $past(gnt_o)) else $error("rvalid_o without a preceding grant");

  no_gnt_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o |-> !gnt_o) else $error("grant while a response is pending");

  // CPU must be held in reset while unpowered
  rst_while_gated: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    powergate_switch_o |-> !cpu_subsystem_rst_no) else $error("CPU out of reset while gated");

  reset_values: assert property (@(posedge clk_i)
    !arst_n_i |-> !gnt_o && !rvalid_o && !exit_valid_o && !timer_irq_o
                  && !powergate_switch_o && cpu_subsystem_rst_no)
    else $error("control outputs not at reset values during reset");

endmodule

`default_nettype wire

// File: bench/tb_ao_peripheral_subsystem.sv
/*
 * Testbench for the always-on peripheral subsystem: bus accesses,
 * strap and exit checks, unmapped window and timer wake-up
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ao_peripheral_subsystem;

  localparam int unsigned RESET_DELAY = 6;

  logic        clk_i;
  logic        arst_n_i;
  logic        req_i;
  logic [31:0] addr_i;
  logic        we_i;
  logic [3:0]  be_i;
  logic [31:0] wdata_i;
  logic        gnt_o;
  logic        rvalid_o;
  logic [31:0] rdata_o;
  logic        boot_select_i;
  logic        execute_from_flash_i;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic        core_sleep_i;
  logic        timer_irq_o;
  logic        powergate_switch_o;
  logic        cpu_subsystem_rst_no;

  ao_peripheral_subsystem #(
    .RESET_DELAY(RESET_DELAY)
  ) UUT (
    .clk_i, .arst_n_i,
    .req_i, .addr_i, .we_i, .be_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o,
    .boot_select_i, .execute_from_flash_i, .exit_valid_o, .exit_value_o,
    .core_sleep_i, .timer_irq_o, .powergate_switch_o, .cpu_subsystem_rst_no
  );

  bind ao_peripheral_subsystem ao_bus_checker bus_checker_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .gnt_o(gnt_o), .rvalid_o(rvalid_o),
    .exit_valid_o(exit_valid_o), .timer_irq_o(timer_irq_o),
    .powergate_switch_o(powergate_switch_o), .cpu_subsystem_rst_no(cpu_subsystem_rst_no)
  );

  always #2 clk_i = ~clk_i;

  // Test lengths stay well below this many cycles
  initial begin
    repeat (2000) @(posedge clk_i);
    $display("Watchdog timeout: the run did not finish in time");
    $display("Simulation FAILED");
    $fatal(1);
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] window_addr(input logic [1:0] idx, input logic [11:0] off);
    return {18'b0, idx, off};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    @(negedge clk_i);
    while (!gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    @(negedge clk_i);
    while (!rvalid_o) @(negedge clk_i);
    rdata = rdata_o;
    @(posedge clk_i);
    #1;
    if (we) check_value("rdata_o (write)", rdata, 32'h0);
  endtask

  // Second read keeps req high through the response cycle of the first
  task automatic read_back_to_back(input logic [31:0] addr_a, input logic [31:0] addr_b,
                                   output logic [31:0] rdata_a, output logic [31:0] rdata_b);
    req_i   = 1'b1;
    we_i    = 1'b0;
    be_i    = 4'hF;
    wdata_i = '0;
    addr_i  = addr_a;
    @(negedge clk_i);
    while (!gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    addr_i = addr_b;
    @(negedge clk_i);
    while (!rvalid_o) @(negedge clk_i);
    rdata_a = rdata_o;
    @(negedge clk_i);
    check_value("gnt_o (back-to-back)", 32'(gnt_o), 32'h1);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    @(negedge clk_i);
    while (!rvalid_o) @(negedge clk_i);
    rdata_b = rdata_o;
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    logic [31:0] seed;
    logic [31:0] v_exit;
    logic [31:0] v_cmp;
    logic [31:0] v_low;
    logic [31:0] rd;
    logic [31:0] rd_b;
    int          cycles;
    seed = 32'd94;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    req_i = 1'b0;
    addr_i = '0;
    we_i = 1'b0;
    be_i = '0;
    wdata_i = '0;
    boot_select_i = 1'b1;
    execute_from_flash_i = 1'b0;
    core_sleep_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    @(negedge clk_i);
    check_value("gnt_o", 32'(gnt_o), 32'h0);
    check_value("rvalid_o", 32'(rvalid_o), 32'h0);
    check_value("exit_valid_o", 32'(exit_valid_o), 32'h0);
    check_value("timer_irq_o", 32'(timer_irq_o), 32'h0);
    check_value("powergate_switch_o", 32'(powergate_switch_o), 32'h0);
    check_value("cpu_subsystem_rst_no", 32'(cpu_subsystem_rst_no), 32'h1);
    @(posedge clk_i);
    #1;

    // Full-word and half-word register writes
    seed = lcg_next(seed);
    v_exit = seed;
    bus_access(1'b1, window_addr(ao_map_pkg::SOC_CTRL_IDX, ao_map_pkg::SOC_CTRL_EXIT_VALUE),
               4'hF, v_exit, rd);
    bus_access(1'b0, window_addr(ao_map_pkg::SOC_CTRL_IDX, ao_map_pkg::SOC_CTRL_EXIT_VALUE),
               4'hF, 32'h0, rd);
    check_value("EXIT_VALUE", rd, v_exit);
    seed = lcg_next(seed);
    v_cmp = seed;
    bus_access(1'b1, window_addr(ao_map_pkg::TIMER_IDX, ao_map_pkg::TIMER_CMP), 4'hF, v_cmp, rd);
    bus_access(1'b0, window_addr(ao_map_pkg::TIMER_IDX, ao_map_pkg::TIMER_CMP), 4'hF, 32'h0, rd);
    check_value("TIMER_CMP", rd, v_cmp);
    seed = lcg_next(seed);
    v_low = seed;
    bus_access(1'b1, window_addr(ao_map_pkg::SOC_CTRL_IDX, ao_map_pkg::SOC_CTRL_EXIT_VALUE),
               4'b0011, v_low, rd);
    v_exit = {v_exit[31:16], v_low[15:0]};
    bus_access(1'b0, window_addr(ao_map_pkg::SOC_CTRL_IDX, ao_map_pkg::SOC_CTRL_EXIT_VALUE),
               4'hF, 32'h0, rd);
    check_value("EXIT_VALUE (be 0011)", rd, v_exit);

    // Straps and exit code
    bus_access(1'b0, window_addr(ao_map_pkg::SOC_CTRL_IDX, ao_map_pkg::SOC_CTRL_BOOT),
               4'hF, 32'h0, rd);
    check_value("SOC_CTRL_BOOT", rd, {30'b0, execute_from_flash_i, boot_select_i});
    bus_access(1'b1, window_addr(ao_map_pkg::SOC_CTRL_IDX, ao_map_pkg::SOC_CTRL_EXIT_VALID),
               4'hF, 32'h1, rd);
    check_value("exit_valid_o", 32'(exit_valid_o), 32'h1);
    check_value("exit_value_o", exit_value_o, v_exit);

    // Window 3 belongs to nobody
    bus_access(1'b0, window_addr(2'd3, 12'h000), 4'hF, 32'h0, rd);
    check_value("rdata_o (unmapped)", rd, 32'hBADCAB1E);
    bus_access(1'b1, window_addr(2'd3, 12'h004), 4'hF, ~v_exit, rd);
    read_back_to_back(window_addr(ao_map_pkg::SOC_CTRL_IDX, ao_map_pkg::SOC_CTRL_EXIT_VALUE),
                      window_addr(ao_map_pkg::TIMER_IDX, ao_map_pkg::TIMER_CMP), rd, rd_b);
    check_value("EXIT_VALUE (after unmapped)", rd, v_exit);
    check_value("TIMER_CMP (after unmapped)", rd_b, v_cmp);

    // Sleep, gate, then wake on the timer
    bus_access(1'b1, window_addr(ao_map_pkg::POWER_IDX, ao_map_pkg::POWER_GATE_EN),
               4'hF, 32'h1, rd);
    bus_access(1'b1, window_addr(ao_map_pkg::POWER_IDX, ao_map_pkg::POWER_WAKE_EN),
               4'hF, 32'h1, rd);
    core_sleep_i = 1'b1;
    @(negedge clk_i);
    while (!powergate_switch_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    core_sleep_i = 1'b0;
    bus_access(1'b0, window_addr(ao_map_pkg::POWER_IDX, ao_map_pkg::POWER_STATUS),
               4'hF, 32'h0, rd);
    check_value("POWER_STATUS (off)", rd, 32'd2);
    check_value("powergate_switch_o", 32'(powergate_switch_o), 32'h1);
    bus_access(1'b0, window_addr(ao_map_pkg::TIMER_IDX, ao_map_pkg::TIMER_MTIME),
               4'hF, 32'h0, rd);
    bus_access(1'b1, window_addr(ao_map_pkg::TIMER_IDX, ao_map_pkg::TIMER_CMP),
               4'hF, rd + 32'd20, rd);
    bus_access(1'b1, window_addr(ao_map_pkg::TIMER_IDX, ao_map_pkg::TIMER_CTRL),
               4'hF, 32'h1, rd);
    @(negedge clk_i);
    while (!timer_irq_o) @(negedge clk_i);
    check_value("powergate_switch_o (irq cycle)", 32'(powergate_switch_o), 32'h1);
    @(negedge clk_i);
    check_value("powergate_switch_o (wake)", 32'(powergate_switch_o), 32'h0);
    cycles = 0;
    while (!cpu_subsystem_rst_no) begin
      @(negedge clk_i);
      cycles++;
    end
    check_value("reset release delay", 32'(cycles), 32'(RESET_DELAY));
    @(posedge clk_i);
    #1;
    bus_access(1'b0, window_addr(ao_map_pkg::POWER_IDX, ao_map_pkg::POWER_STATUS),
               4'hF, 32'h0, rd);
    check_value("POWER_STATUS (on)", rd, 32'd0);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/bus_pkg.sv
design/ao_map_pkg.sv
design/obi_to_reg.sv
design/reg_decode_demux.sv
design/soc_ctrl.sv
design/ao_timer.sv
design/power_manager.sv
design/ao_peripheral_subsystem.sv
bench/ao_bus_checker.sv
bench/tb_ao_peripheral_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the always-on subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f list.f --top-module tb_ao_peripheral_subsystem \
  -o tb_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
grep -q "Simulation PASSED" <<< "$out" && echo "Run passed" || { echo "Run failed"; exit 1; }
